/* processor.f */
rtl/cpuPkg.sv
rtl/memoryPort.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/aluLane.sv
rtl/conditionUnit.sv
rtl/processor.sv
bench/tbClock.sv
bench/processor_asserts.sv
bench/processorTb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - files:
      - rtl/cpuPkg.sv
      - rtl/memoryPort.sv
      - rtl/controlUnit.sv
      - rtl/registerFile.sv
      - rtl/aluLane.sv
      - rtl/conditionUnit.sv
      - rtl/processor.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/processor_asserts.sv
      - bench/processorTb.sv

/* bench/processorTb.sv */
`default_nettype none

module processorTb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpuPkg::*;

	localparam int ROM_BITS = 12;
	localparam addrT RESET_VECTOR = addrT'(16'hFFFF << ROM_BITS);
	localparam int NUM_PROGRAMS = 8;
	localparam int PROGRAM_LEN = 40;
	localparam int CYCLES_PER_INSTR = 16;
	localparam int CLOCK_PERIOD = 8;
	localparam int WATCHDOG_NS = NUM_PROGRAMS * PROGRAM_LEN * CYCLES_PER_INSTR * CLOCK_PERIOD * 2;
	localparam int HALT_SETTLE = 8; // idle cycles watched after halted

	logic clock;
	logic reset_;
	logic restart;
	addrT addr;
	byteT readData;
	byteT writeData;
	logic mr_;
	logic mw_;
	logic halted;

	integer seed = 67805;
	int checkCount = 0;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	byteT mem [0:65535];
	addrT gotAddr [$];
	byteT gotData [$];
	addrT expAddr [$];
	byteT expData [$];
	logic firstReadSeen = 1'b0;
	addrT firstReadAddr;
	int strobesAfterHalt = 0;
	int modelSteps;

	tbClock u_tbClock (
		.clock(clock),
		.reset_(reset_),
		.restart(restart)
	);

	processor #(
		.ROM_BITS(ROM_BITS)
	) u_processor (
		.clock(clock),
		.reset_(reset_),
		.addr(addr),
		.readData(readData),
		.writeData(writeData),
		.mr_(mr_),
		.mw_(mw_),
		.halted(halted)
	);

	// memory answers in the same cycle
	assign readData = $isunknown(addr) ? 8'h00 : mem[addr];

	// bus monitor samples the strobes at the falling edge
	always @(negedge clock) begin
		if (reset_ === 1'b0) begin
			if (halted && (!mr_ || !mw_))
				strobesAfterHalt++;
			if (!mw_) begin
				gotAddr.push_back(addr);
				gotData.push_back(writeData);
			end
			if (!mr_ && !firstReadSeen) begin
				firstReadAddr = addr;
				firstReadSeen = 1'b1;
			end
		end
	end

	function automatic int randomBelow(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic int instrLength(input byteT op);
		case (op[7:5])
			3'b100: return 2;         // immediate byte
			3'b110, 3'b111: return 3; // word address
			default: return 1;
		endcase
	endfunction

	// 26 ALU opcodes over the four pairings
	function automatic byteT aluOpcode(input int index);
		if (index < 8)
			return byteT'(8'h01 + index);
		else if (index < 13)
			return byteT'(8'h11 + index - 8);
		else if (index < 16)
			return byteT'(8'h26 + index - 13);
		else if (index < 21)
			return byteT'(8'h81 + index - 16);
		else
			return byteT'(8'h91 + index - 21);
	endfunction

	function automatic byteT randomOpcode();
		int pick;
		pick = randomBelow(10);
		case (pick)
			0, 1: return randomBelow(2) ? 8'h86 : 8'h80;
			2: return 8'h09 + byteT'(randomBelow(3)); // nop and moves
			3, 4, 5: return aluOpcode(randomBelow(26));
			6, 7: return randomBelow(2) ? 8'hC1 : 8'hC0;
			default: return 8'hE0 + byteT'(randomBelow(19));
		endcase
	endfunction

	// F2, F3 or F5
	function automatic byteT droppedOpcode();
		logic [2:0] fmt;
		int pick;
		pick = randomBelow(3);
		case (pick)
			0: fmt = 3'b010;
			1: fmt = 3'b011;
			default: fmt = 3'b101;
		endcase
		return {fmt, 5'(randomBelow(32))};
	endfunction

	task automatic fillMemory();
		addrT a;
		for (int i = 0; i < 65536; i++) begin
			a = addrT'(i);
			mem[a] = a[15:8] ^ a[7:0] ^ 8'h5A;
		end
	endtask

	task automatic buildProgram(input int index);
		byteT ops [PROGRAM_LEN + 1];
		addrT starts [PROGRAM_LEN + 1];
		addrT at;
		int target;
		at = RESET_VECTOR;
		for (int i = 0; i < PROGRAM_LEN; i++) begin
			ops[i] = randomOpcode();
			starts[i] = at;
			at = at + addrT'(instrLength(ops[i]));
		end
		starts[PROGRAM_LEN] = at;
		ops[PROGRAM_LEN] = (index < NUM_PROGRAMS / 2) ? 8'h00 : droppedOpcode();
		mem[at] = ops[PROGRAM_LEN];
		for (int i = 0; i < PROGRAM_LEN; i++) begin
			at = starts[i];
			mem[at] = ops[i];
			if (instrLength(ops[i]) == 2) begin
				mem[at + 16'd1] = byteT'(randomBelow(256));
			end else if (ops[i][7:5] == 3'b111) begin
				target = i + 1 + randomBelow(PROGRAM_LEN - i); // forward only
				mem[at + 16'd1] = starts[target][7:0];
				mem[at + 16'd2] = starts[target][15:8];
			end else if (instrLength(ops[i]) == 3) begin
				mem[at + 16'd1] = byteT'(randomBelow(256));
				mem[at + 16'd2] = 8'h00; // stores land in page zero
			end
		end
	endtask

	task automatic aluModel(input aluOpT op, input byteT d, input byteT s,
			output byteT r, output flagsT f);
		byteT diff;
		logic [8:0] wide;
		diff = d - s;
		f = '0;
		case (op)
			opAdd: begin
				wide = d + s;
				r = wide[7:0];
				f.cf = wide[8];
				f.of = (d[7] == s[7]) && (r[7] != d[7]);
			end
			opSub, opCmp: begin
				r = (op == opCmp) ? d : diff;
				f.cf = (d < s); // borrow
				f.of = (d[7] != s[7]) && (diff[7] != d[7]);
			end
			opAnd: r = d & s;
			opOr: r = d | s;
			opShl: begin
				r = d << 1;
				f.cf = d[7];
			end
			opShr: begin
				r = d >> 1;
				f.cf = d[0];
			end
			default: r = ~d;
		endcase
		f.zf = (((op == opCmp) ? diff : r) == 8'h00);
		f.sf = (op == opCmp) ? diff[7] : r[7];
	endtask

	function automatic logic conditionMet(input logic [4:0] cc, input flagsT f);
		case (cc)
			5'd0: return 1'b1;
			5'd1, 5'd11: return f.zf;
			5'd2, 5'd12: return !f.zf;
			5'd3: return !f.cf && !f.zf;  // unsigned above
			5'd4, 5'd14: return !f.cf;
			5'd5, 5'd13: return f.cf;
			5'd6: return f.cf || f.zf;
			5'd7: return !f.zf && (f.sf == f.of);
			5'd8: return f.sf == f.of;
			5'd9: return f.sf != f.of;
			5'd10: return f.zf || (f.sf != f.of);
			5'd15: return f.of;
			5'd16: return !f.of;
			5'd17: return f.sf;
			default: return !f.sf;
		endcase
	endfunction

	// instruction-set model that fills the expected write list
	task automatic runModel();
		byteT al;
		byteT ah;
		flagsT fl;
		addrT ip;
		byteT op;
		byteT imm;
		addrT target;
		byteT result;
		flagsT newFlags;
		byteT src;
		logic toAh;
		logic running;
		al = 8'h00;
		ah = 8'h00;
		fl = '0;
		ip = RESET_VECTOR;
		running = 1'b1;
		modelSteps = 0;
		expAddr.delete();
		expData.delete();
		while (running && modelSteps < 4 * PROGRAM_LEN) begin
			op = mem[ip];
			imm = mem[ip + 16'd1];
			target = {mem[ip + 16'd2], mem[ip + 16'd1]};
			ip = ip + addrT'(instrLength(op));
			modelSteps++;
			case (op) inside
				8'h09: ;
				8'h0A: ah = al;
				8'h0B: al = ah;
				8'h80: al = imm;
				8'h86: ah = imm;
				8'hC0, 8'hC1: begin
					expAddr.push_back(target);
					expData.push_back(op[0] ? ah : al);
				end
				[8'h01:8'h08], [8'h11:8'h15], [8'h26:8'h28],
				[8'h81:8'h85], [8'h91:8'h95]: begin
					toAh = op[4] || (op[7:5] == 3'b001);
					if (op[7:5] == 3'b100)
						src = imm;
					else
						src = toAh ? al : ah;
					aluModel(aluOpT'(op[3:0]), toAh ? ah : al, src, result, newFlags);
					fl = newFlags;
					if (op[3:0] != 4'd1) begin // cmp keeps dest
						if (toAh)
							ah = result;
						else
							al = result;
					end
				end
				[8'hE0:8'hF2]: if (conditionMet(op[4:0], fl)) ip = target;
				default: running = 1'b0; // hlt or dropped format
			endcase
		end
	endtask

	task automatic compareByte(input string name, input byteT got, input byteT expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
		end
	endtask

	task automatic compareAddr(input string name, input addrT got, input addrT expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
		end
	endtask

	task automatic compareHalt(input logic got, input logic expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("** Error at %0t ns: halted expected %b, got %b", $time, expected, got);
		end
	endtask

	task automatic applyReset();
		gotAddr.delete();
		gotData.delete();
		firstReadSeen = 1'b0;
		strobesAfterHalt = 0;
		@(posedge clock);
		restart <= 1'b1;
		@(posedge clock);
		restart <= 1'b0;
		wait (reset_ === 1'b1);
		wait (reset_ === 1'b0);
	endtask

	task automatic checkProgram(input int index);
		compareHalt(halted, 1'b1);
		if (!firstReadSeen) begin
			errorCount++;
			$display("program %0d: no read strobe after reset", index);
		end else begin
			compareAddr("addr", firstReadAddr, RESET_VECTOR);
		end
		if (gotAddr.size() != expAddr.size()) begin
			errorCount++;
			$display("program %0d: %0d bus writes seen but %0d predicted",
				index, gotAddr.size(), expAddr.size());
		end
		for (int i = 0; i < gotAddr.size() && i < expAddr.size(); i++) begin
			compareAddr("addr", gotAddr[i], expAddr[i]);
			compareByte("writeData", gotData[i], expData[i]);
		end
		if (strobesAfterHalt != 0) begin
			errorCount++;
			$display("program %0d: bus strobes kept going after halted", index);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the DUT never finished", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int errorsBefore;
		int assertFailures;
		restart = 1'b0;
		fillMemory();
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			errorsBefore = errorCount;
			buildProgram(p);
			runModel();
			applyReset();
			compareHalt(halted, 1'b0); // low again after reset
			while (halted !== 1'b1)
				@(posedge clock);
			repeat (HALT_SETTLE) @(posedge clock);
			checkProgram(p);
			if (errorCount == errorsBefore)
				testsPassed++;
			else
				testsFailed++;
			$display("program %0d: %0d instructions, %0d writes, %s", p, modelSteps,
				expAddr.size(), (errorCount == errorsBefore) ? "passed" : "failed");
		end
		assertFailures = u_processor.u_processorAsserts.failCount;
		$display("%0d tests passed, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			testsPassed, testsFailed, checkCount, errorCount, assertFailures);
		if (errorCount == 0 && assertFailures == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/processor_asserts.sv */
`default_nettype none

module processor_asserts (
	input wire logic clock,
	input wire logic reset_,
	input wire logic mr_,
	input wire logic mw_,
	input wire logic halted
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned failCount = 0; // read by the testbench at the end

	// one strobe at a time on the shared bus
	strobesExclusive: assert property (@(posedge clock) disable iff (reset_) !(!mr_ && !mw_))
		else begin
			failCount++;
			$error("mr_ and mw_ are low in the same cycle");
		end

	writeStrobeOneCycle: assert property (@(posedge clock) disable iff (reset_)
		$fell(mw_) |=> mw_)
		else begin
			failCount++;
			$error("mw_ stayed low for more than one cycle");
		end

	// only a reset can clear halted
	haltedSticky: assert property (@(posedge clock) $fell(halted) |-> $past(reset_))
		else begin
			failCount++;
			$error("halted fell without a reset");
		end

	strobesIdleAfterReset: assert property (@(posedge clock) reset_ |=> (mr_ && mw_))
		else begin
			failCount++;
			$error("bus strobe active right after reset");
		end

endmodule

bind processor processor_asserts u_processorAsserts (
	.clock(clock),
	.reset_(reset_),
	.mr_(mr_),
	.mw_(mw_),
	.halted(halted)
);

`default_nettype wire

/* bench/tbClock.sv */
`default_nettype none

module tbClock (
	output logic      clock,
	output logic      reset_,
	input  wire logic restart
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 4; // 8 ns clock
	localparam int RESET_CYCLES = 2;

	int cyclesLeft;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	initial begin
		reset_ = 1'b1;
		cyclesLeft = RESET_CYCLES;
	end

	// restart gives another reset of the same length
	always @(posedge clock) begin
		if (restart) begin
			reset_ <= 1'b1;
			cyclesLeft <= RESET_CYCLES;
		end else if (cyclesLeft > 1) begin
			cyclesLeft <= cyclesLeft - 1;
		end else begin
			reset_ <= 1'b0;
			cyclesLeft <= 0;
		end
	end

endmodule

`default_nettype wire

/* rtl/processor.sv */
`default_nettype none

module processor #(
	parameter int ROM_BITS = 12
) (
	input  wire logic           clock,
	input  wire logic           reset_,
	output cpuPkg::addrT        addr,
	input  wire cpuPkg::byteT   readData,
	output cpuPkg::byteT        writeData,
	output logic                mr_,
	output logic                mw_,
	output logic                halted
);
	import cpuPkg::*;

	logic memValid;
	logic memReady;
	logic memWrite;
	logic memWord;
	addrT memAddr;
	byteT memWriteData;
	logic memDone;
	byteT memData0;
	byteT memData1;
	byteT al;
	byteT ah;
	byteT sourceByte;
	aluOpT aluOp;
	laneT laneSel;
	logic [4:0] condCode;
	logic jumpTaken;
	logic aluExecute;
	logic loadAl;
	logic loadAh;
	logic moveAlToAh;
	logic moveAhToAl;
	byteT writeBack;
	logic writeAl;
	logic writeAh;
	byteT laneResult [4];
	flagsT laneFlags [4];

	memoryPort u_memoryPort (
		.clock(clock),
		.reset_(reset_),
		.memValid(memValid),
		.memReady(memReady),
		.memWrite(memWrite),
		.memWord(memWord),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memDone(memDone),
		.memData0(memData0),
		.memData1(memData1),
		.addr(addr),
		.readData(readData),
		.writeData(writeData),
		.mr_(mr_),
		.mw_(mw_)
	);

	controlUnit #(
		.ROM_BITS(ROM_BITS)
	) u_controlUnit (
		.clock(clock),
		.reset_(reset_),
		.memValid(memValid),
		.memReady(memReady),
		.memWrite(memWrite),
		.memWord(memWord),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memDone(memDone),
		.memData0(memData0),
		.memData1(memData1),
		.al(al),
		.ah(ah),
		.aluOp(aluOp),
		.laneSel(laneSel),
		.sourceByte(sourceByte),
		.condCode(condCode),
		.jumpTaken(jumpTaken),
		.aluExecute(aluExecute),
		.loadAl(loadAl),
		.loadAh(loadAh),
		.moveAlToAh(moveAlToAh),
		.moveAhToAl(moveAhToAl),
		.halted(halted)
	);

	registerFile u_registerFile (
		.clock(clock),
		.reset_(reset_),
		.loadAl(loadAl),
		.loadAh(loadAh),
		.moveAlToAh(moveAlToAh),
		.moveAhToAl(moveAhToAl),
		.sourceByte(sourceByte),
		.writeBack(writeBack),
		.writeAl(writeAl),
		.writeAh(writeAh),
		.al(al),
		.ah(ah)
	);

	// one lane per destination/source pairing
	for (genvar lane = 0; lane < 4; lane++) begin : genLane
		localparam laneT PAIRING = laneT'(lane);
		byteT dest;
		byteT source;

		assign dest = (PAIRING == laneAl || PAIRING == laneAhAl) ? al : ah;
		assign source = (PAIRING == laneAhAl) ? ah :
			(PAIRING == laneAlAh) ? al : sourceByte;

		aluLane u_aluLane (
			.aluOp(aluOp),
			.dest(dest),
			.source(source),
			.laneResult(laneResult[lane]),
			.laneFlags(laneFlags[lane])
		);
	end

	conditionUnit u_conditionUnit (
		.clock(clock),
		.reset_(reset_),
		.aluOp(aluOp),
		.laneSel(laneSel),
		.laneResult(laneResult),
		.laneFlags(laneFlags),
		.aluExecute(aluExecute),
		.condCode(condCode),
		.flags(),
		.jumpTaken(jumpTaken),
		.writeBack(writeBack),
		.writeAl(writeAl),
		.writeAh(writeAh)
	);

endmodule

`default_nettype wire

/* rtl/conditionUnit.sv */
`default_nettype none

module conditionUnit (
	input  wire logic           clock,
	input  wire logic           reset_,
	input  wire cpuPkg::aluOpT  aluOp,
	input  wire cpuPkg::laneT   laneSel,
	input  wire cpuPkg::byteT   laneResult [4],
	input  wire cpuPkg::flagsT  laneFlags [4],
	input  wire logic           aluExecute,
	input  wire logic [4:0]     condCode,
	output cpuPkg::flagsT       flags,
	output logic                jumpTaken,
	output cpuPkg::byteT        writeBack,
	output logic                writeAl,
	output logic                writeAh
);
	import cpuPkg::*;

	// opcode bits 4..0 of the jump group
	typedef enum logic [4:0] {
		condJmp,
		condJe,
		condJne,
		condJa,
		condJae,
		condJb,
		condJbe,
		condJg,
		condJge,
		condJl,
		condJle,
		condJz,
		condJnz,
		condJc,
		condJnc,
		condJo,
		condJno,
		condJs,
		condJns
	} condT;

	logic writeLane;

	assign writeBack = laneResult[laneSel];
	assign writeLane = aluExecute && (aluOp != opCmp);
	assign writeAl = writeLane && (laneSel == laneAl || laneSel == laneAhAl);
	assign writeAh = writeLane && (laneSel == laneAh || laneSel == laneAlAh);

	always_ff @(posedge clock) begin
		if (reset_)
			flags <= '0;
		else if (aluExecute)
			flags <= laneFlags[laneSel];
	end

	always_comb begin
		case (condT'(condCode))
			condJmp:        jumpTaken = 1'b1;
			condJe, condJz:   jumpTaken = flags.zf;
			condJne, condJnz: jumpTaken = !flags.zf;
			condJa:         jumpTaken = !flags.zf && !flags.cf; // unsigned above
			condJae, condJnc: jumpTaken = !flags.cf;
			condJb, condJc:   jumpTaken = flags.cf;
			condJbe:        jumpTaken = flags.zf || flags.cf;
			condJg:         jumpTaken = !flags.zf && (flags.of == flags.sf);
			condJge:        jumpTaken = (flags.of == flags.sf);
			condJl:         jumpTaken = (flags.of != flags.sf);
			condJle:        jumpTaken = flags.zf || (flags.of != flags.sf);
			condJo:         jumpTaken = flags.of;
			condJno:        jumpTaken = !flags.of;
			condJs:         jumpTaken = flags.sf;
			condJns:        jumpTaken = !flags.sf;
			default:        jumpTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/aluLane.sv */
`default_nettype none

module aluLane (
	input  wire cpuPkg::aluOpT  aluOp,
	input  wire cpuPkg::byteT   dest,
	input  wire cpuPkg::byteT   source,
	output cpuPkg::byteT        laneResult,
	output cpuPkg::flagsT       laneFlags
);
	import cpuPkg::*;

	logic [8:0] sum;
	logic [8:0] diff; // bit 8 is the borrow
	logic addOverflow;
	logic subOverflow;
	byteT flagSource;

	assign sum = {1'b0, dest} + {1'b0, source};
	assign diff = {1'b0, dest} - {1'b0, source};
	assign addOverflow = (dest[7] == source[7]) && (sum[7] != dest[7]);
	assign subOverflow = (dest[7] != source[7]) && (diff[7] != dest[7]);

	always_comb begin
		laneFlags.of = 1'b0;
		laneFlags.cf = 1'b0;
		case (aluOp)
			opCmp: begin
				laneResult = dest; // compare only, dest kept
				laneFlags.of = subOverflow;
				laneFlags.cf = diff[8];
			end
			opAdd: begin
				laneResult = sum[7:0];
				laneFlags.of = addOverflow;
				laneFlags.cf = sum[8];
			end
			opSub: begin
				laneResult = diff[7:0];
				laneFlags.of = subOverflow;
				laneFlags.cf = diff[8];
			end
			opAnd: laneResult = dest & source;
			opOr:  laneResult = dest | source;
			opShl: begin
				laneResult = {dest[6:0], 1'b0};
				laneFlags.cf = dest[7];
			end
			opShr: begin
				laneResult = {1'b0, dest[7:1]}; // top bit zero, so sf clear
				laneFlags.cf = dest[0];
			end
			opNot: laneResult = ~dest;
			default: laneResult = dest;
		endcase

		// zf and sf follow the produced value, cmp uses the difference
		flagSource = (aluOp == opCmp) ? diff[7:0] : laneResult;
		laneFlags.zf = (flagSource == 8'h00);
		laneFlags.sf = flagSource[7];
	end

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
`default_nettype none

module registerFile (
	input  wire logic           clock,
	input  wire logic           reset_,
	input  wire logic           loadAl,
	input  wire logic           loadAh,
	input  wire logic           moveAlToAh,
	input  wire logic           moveAhToAl,
	input  wire cpuPkg::byteT   sourceByte,
	input  wire cpuPkg::byteT   writeBack,
	input  wire logic           writeAl,
	input  wire logic           writeAh,
	output cpuPkg::byteT        al,
	output cpuPkg::byteT        ah
);

	// loads win over moves, moves over ALU writeback
	always_ff @(posedge clock) begin
		if (reset_) begin
			al <= '0;
			ah <= '0;
		end else begin
			if (loadAl)
				al <= sourceByte;
			else if (moveAhToAl)
				al <= ah;
			else if (writeAl)
				al <= writeBack;

			if (loadAh)
				ah <= sourceByte;
			else if (moveAlToAh)
				ah <= al;
			else if (writeAh)
				ah <= writeBack;
		end
	end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`default_nettype none

module controlUnit #(
	parameter int ROM_BITS = 12
) (
	input  wire logic           clock,
	input  wire logic           reset_,
	output logic                memValid,
	input  wire logic           memReady,
	output logic                memWrite,
	output logic                memWord,
	output cpuPkg::addrT        memAddr,
	output cpuPkg::byteT        memWriteData,
	input  wire logic           memDone,
	input  wire cpuPkg::byteT   memData0,
	input  wire cpuPkg::byteT   memData1,
	input  wire cpuPkg::byteT   al,
	input  wire cpuPkg::byteT   ah,
	output cpuPkg::aluOpT       aluOp,
	output cpuPkg::laneT        laneSel,
	output cpuPkg::byteT        sourceByte,
	output logic [4:0]          condCode,
	input  wire logic           jumpTaken,
	output logic                aluExecute,
	output logic                loadAl,
	output logic                loadAh,
	output logic                moveAlToAh,
	output logic                moveAhToAl,
	output logic                halted
);
	import cpuPkg::*;

	// upper address bits set, ROM area below
	localparam addrT RESET_VECTOR = {{(ADDR_WIDTH - ROM_BITS){1'b1}}, {ROM_BITS{1'b0}}};

	typedef enum logic [3:0] {
		insHlt,
		insNop,
		insMoveAlAh,
		insMoveAhAl,
		insLoadAl,
		insLoadAh,
		insStore,
		insAlu,
		insJump,
		insInvalid
	} instrT;

	cpuStateT state;
	addrT ip;
	byteT opcode;
	addrT destAddr;
	formatT format;
	instrT instr;
	logic storeSel;

	function automatic instrT classify(input byteT op);
		instrT kind;
		case (op) inside
			8'h00: kind = insHlt;
			8'h09: kind = insNop;
			8'h0A: kind = insMoveAlAh;
			8'h0B: kind = insMoveAhAl;
			8'h80: kind = insLoadAl;
			8'h86: kind = insLoadAh;
			8'hC0, 8'hC1: kind = insStore;
			[8'h01:8'h08], [8'h11:8'h15], [8'h26:8'h28]: kind = insAlu;
			[8'h81:8'h85], [8'h91:8'h95]: kind = insAlu;
			[8'hE0:8'hF2]: kind = insJump; // F3 was call
			default: kind = insInvalid;
		endcase
		return kind;
	endfunction

	assign format = formatT'(opcode[7:5]);
	assign instr = classify(opcode);
	assign aluOp = aluOpT'(opcode[3:0]);
	assign condCode = opcode[4:0];
	assign storeSel = opcode[0]; // C1 stores AH

	always_comb begin
		case (format)
			fmtImm: laneSel = opcode[4] ? laneAh : laneAl;
			fmtReg: laneSel = laneAh; // not/shl/shr on AH
			default: begin
				if (opcode[4])
					laneSel = laneAlAh;
				else if (opcode[3:0] >= 4'd6)
					laneSel = laneAl; // single operand ops on AL
				else
					laneSel = laneAhAl;
			end
		endcase
	end

	assign aluExecute = (state == execute) && (instr == insAlu);
	assign loadAl = (state == execute) && (instr == insLoadAl);
	assign loadAh = (state == execute) && (instr == insLoadAh);
	assign moveAlToAh = (state == execute) && (instr == insMoveAlAh);
	assign moveAhToAl = (state == execute) && (instr == insMoveAhAl);
	assign halted = (state == halt) || (state == invalid);

	always_ff @(posedge clock) begin
		if (reset_) begin
			state <= fetchOp;
			ip <= RESET_VECTOR;
			memValid <= 1'b0;
			memWrite <= 1'b0;
			memWord <= 1'b0;
		end else begin
			if (memValid && memReady)
				memValid <= 1'b0; // one request in flight
			case (state)
				fetchOp: begin
					memValid <= 1'b1;
					memWrite <= 1'b0;
					memWord <= 1'b0;
					ip <= ip + 16'd1;
					state <= fetchWait;
				end
				fetchWait: if (memDone) state <= decode;
				decode: begin
					case (format)
						fmtNone, fmtReg:
							state <= (instr == insInvalid) ? invalid : execute;
						fmtImm, fmtDirDst, fmtJump:
							state <= (instr == insInvalid) ? invalid : fetchOperand;
						default: state <= invalid; // memory-indirect sources
					endcase
				end
				fetchOperand: begin
					memValid <= 1'b1;
					memWrite <= 1'b0;
					memWord <= (format != fmtImm);
					ip <= (format == fmtImm) ? ip + 16'd1 : ip + 16'd2;
					state <= fetchOperandWait;
				end
				fetchOperandWait: if (memDone) state <= execute;
				execute: begin
					case (instr)
						insHlt: state <= halt;
						insStore: begin
							memValid <= 1'b1;
							memWrite <= 1'b1;
							memWord <= 1'b0;
							state <= storeWait;
						end
						insJump: begin
							if (jumpTaken)
								ip <= destAddr;
							state <= fetchOp;
						end
						default: state <= fetchOp;
					endcase
				end
				storeWait: if (memDone) state <= fetchOp;
				halt: state <= halt;
				default: state <= invalid;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			fetchOp, fetchOperand: memAddr <= ip;
			fetchWait: if (memDone) opcode <= memData0;
			fetchOperandWait: begin
				if (memDone) begin
					sourceByte <= memData0;
					destAddr <= {memData1, memData0};
				end
			end
			execute: begin
				memAddr <= destAddr;
				memWriteData <= storeSel ? ah : al;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/memoryPort.sv */
`default_nettype none

module memoryPort (
	input  wire logic           clock,
	input  wire logic           reset_,
	input  wire logic           memValid,
	output logic                memReady,
	input  wire logic           memWrite,
	input  wire logic           memWord,
	input  wire cpuPkg::addrT   memAddr,
	input  wire cpuPkg::byteT   memWriteData,
	output logic                memDone,
	output cpuPkg::byteT        memData0,
	output cpuPkg::byteT        memData1,
	output cpuPkg::addrT        addr,
	input  wire cpuPkg::byteT   readData,
	output cpuPkg::byteT        writeData,
	output logic                mr_,
	output logic                mw_
);
	import cpuPkg::*;

	memStateT state;
	logic wordReq;
	logic accept;

	assign memReady = (state == idle);
	assign accept = memValid && memReady;
	assign memDone = (state == readEnd) || (state == write1);

	// strobes straight from the state register
	assign mr_ = !((state == read0) || (state == read1));
	assign mw_ = (state != write0);

	always_ff @(posedge clock) begin
		if (reset_) begin
			state <= idle;
		end else begin
			case (state)
				idle:    if (accept) state <= memWrite ? write0 : read0;
				read0:   state <= wordReq ? read1 : readEnd;
				read1:   state <= readEnd;
				readEnd: state <= idle;
				write0:  state <= write1;
				write1:  state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// bus address, write data and the two read holding bytes
	always_ff @(posedge clock) begin
		if (accept) begin
			addr <= memAddr;
			writeData <= memWriteData;
			wordReq <= memWord;
		end
		if (state == read0) begin
			memData0 <= readData; // low byte first
			if (wordReq)
				addr <= addr + 1'b1;
		end
		if (state == read1)
			memData1 <= readData;
	end

endmodule

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int ADDR_WIDTH = 16; // built from two bytes

	typedef logic [7:0] byteT;
	typedef logic [ADDR_WIDTH-1:0] addrT;

	// of in bit 3 down to cf in bit 0
	typedef struct packed {
		logic of;
		logic sf;
		logic zf;
		logic cf;
	} flagsT;

	// opcode bits 7..5
	typedef enum logic [2:0] {
		fmtNone   = 3'b000,
		fmtReg    = 3'b001,
		fmtIndDp  = 3'b010, // decodes as invalid
		fmtDp     = 3'b011, // decodes as invalid
		fmtImm    = 3'b100, // one immediate byte
		fmtDirSrc = 3'b101, // decodes as invalid
		fmtDirDst = 3'b110, // word address follows
		fmtJump   = 3'b111  // word address follows
	} formatT;

	// opcode bits 3..0
	typedef enum logic [3:0] {
		opCmp = 4'd1,
		opAdd = 4'd2,
		opSub = 4'd3,
		opAnd = 4'd4,
		opOr  = 4'd5,
		opShl = 4'd6,
		opShr = 4'd7,
		opNot = 4'd8
	} aluOpT;

	// destination and source of each ALU lane
	typedef enum logic [1:0] {
		laneAl   = 2'd0, // AL op= fetched byte
		laneAh   = 2'd1, // AH op= fetched byte
		laneAhAl = 2'd2, // AL op= AH
		laneAlAh = 2'd3  // AH op= AL
	} laneT;

	typedef enum logic [4:0] {
		fetchOp,
		fetchWait,
		decode,
		fetchOperand,
		fetchOperandWait,
		execute,
		storeWait,
		halt,
		invalid
	} cpuStateT;

	typedef enum logic [2:0] {
		idle,
		read0,
		read1,
		readEnd,
		write0,
		write1
	} memStateT;

endpackage

`default_nettype wire
